// ==== source/ahb_pkg.sv ====
package ahb_pkg;

  // bus widths
  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [1:0]  htrans_t;

  // transfer types used here
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;

  // address phase, master to slaves
  typedef struct packed {
    haddr_t  haddr;
    htrans_t htrans;
    logic    hwrite;
    logic    hready;
  } ahb_req_t;

  // slave response
  typedef struct packed {
    hdata_t hrdata;
    logic   hreadyout;
    logic   hresp;
  } ahb_rsp_t;

  // address map, slot in haddr[13:12]
  typedef logic [1:0] slot_t;
  localparam slot_t SLOT_SEG7 = 2'd0;
  localparam slot_t SLOT_UART = 2'd1;
  localparam int    SLOT_LSB  = 12;

endpackage

// ==== source/periph_pkg.sv ====
package periph_pkg;

  // display types
  typedef logic [3:0] digit_t;
  // bit 7 is dp, bits 6..0 are g..a, active high
  typedef logic [7:0] seg_t;

  typedef logic [7:0] uart_byte_t;

  // register offsets inside a slot
  localparam logic [11:0] REG_DATA   = 12'h000;
  localparam logic [11:0] REG_STATUS = 12'h004;

  // uart transmitter states
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_t;

  // 595 frame engine states
  typedef enum logic [1:0] {
    LOAD,
    SHIFT,
    LATCH
  } shift_state_t;

endpackage

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx
  import periph_pkg::*;
#(
  parameter int BAUD_DIV = 8
)
(
  input  logic       CLK_CM3,
  input  logic       rst_n,
  input  logic       start,
  input  uart_byte_t data,
  output logic       busy,
  output logic       tx
);

  localparam int BW = $clog2(BAUD_DIV + 1);

  tx_state_t     state;
  logic [BW-1:0] baud_cnt;
  logic          baud_done;
  logic [2:0]    bit_cnt;
  uart_byte_t    shreg;

  assign baud_done = (baud_cnt == BW'(BAUD_DIV - 1));
  assign busy      = (state != IDLE);

  // byte shifter, LSB first
  always_ff @(posedge CLK_CM3)
  begin
    if (state == IDLE && start)
    begin
      shreg <= data;
    end
    else if (state == DATA && baud_done)
    begin
      shreg <= shreg >> 1;
    end
  end

  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      baud_cnt <= (state == IDLE || baud_done) ? '0 : baud_cnt + 1'b1;
      case (state)
        IDLE:
        begin
          if (start)
          begin
            tx    <= 1'b0;
            state <= START;
          end
        end
        START:
        begin
          if (baud_done)
          begin
            tx      <= shreg[0];
            bit_cnt <= '0;
            state   <= DATA;
          end
        end
        DATA:
        begin
          if (baud_done && bit_cnt == 3'd7)
          begin
            // stop bit
            tx    <= 1'b1;
            state <= STOP;
          end
          else if (baud_done)
          begin
            tx      <= shreg[1];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default:
        begin
          if (baud_done)
          begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== source/ahb_uart.sv ====
`timescale 1ns/10ps

module ahb_uart
  import ahb_pkg::*;
  import periph_pkg::*;
#(
  parameter int BAUD_DIV = 8
)
(
  input  logic     CLK_CM3,
  input  logic     rst_n,
  input  logic     sel,
  input  ahb_req_t bus_req,
  input  hdata_t   hwdata,
  output ahb_rsp_t rsp,
  output logic     tx
);

  logic        act_q;
  logic        wr_q;
  logic [11:0] offset_q;
  uart_byte_t  tx_data;
  logic        data_wr;
  logic        start;
  logic        busy;

  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      act_q <= 1'b0;
      wr_q  <= 1'b0;
    end
    else
    begin
      act_q <= sel && (bus_req.htrans == HTRANS_NONSEQ) && bus_req.hready;
      wr_q  <= bus_req.hwrite;
    end
  end

  always_ff @(posedge CLK_CM3)
  begin
    offset_q <= bus_req.haddr[11:0];
  end

  assign data_wr = act_q && wr_q && (offset_q == REG_DATA);
  // write while busy is dropped
  assign start   = data_wr && !busy;

  // last written byte, for readback
  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_data <= '0;
    end
    else if (data_wr)
    begin
      tx_data <= hwdata[7:0];
    end
  end

  always_comb
  begin
    rsp.hrdata    = '0;
    rsp.hreadyout = 1'b1;
    rsp.hresp     = 1'b0;
    if (act_q && !wr_q)
    begin
      if (offset_q == REG_DATA)
      begin
        rsp.hrdata = {24'd0, tx_data};
      end
      else if (offset_q == REG_STATUS)
      begin
        rsp.hrdata = {31'd0, busy};
      end
    end
  end

  uart_tx #(.BAUD_DIV(BAUD_DIV)) u_tx (
    .CLK_CM3 (CLK_CM3),
    .rst_n   (rst_n),
    .start   (start),
    .data    (hwdata[7:0]),
    .busy    (busy),
    .tx      (tx)
  );

endmodule

// ==== source/seg7_shifter.sv ====
`timescale 1ns/10ps

module seg7_shifter
  import ahb_pkg::*;
  import periph_pkg::*;
#(
  parameter int SHIFT_DIV = 2
)
(
  input  logic   CLK_CM3,
  input  logic   rst_n,
  input  hdata_t display,
  output logic   sh_clk,
  output logic   ld_clk,
  output logic   ds
);

  localparam int DW = $clog2(SHIFT_DIV + 1);

  shift_state_t  state;
  logic [DW-1:0] div_cnt;
  logic          div_done;
  logic [3:0]    bit_cnt;
  logic [2:0]    digit_idx;
  logic [15:0]   frame;
  digit_t        cur_digit;

  function automatic seg_t hex_to_seg(input digit_t d);
    case (d)
      4'h0: return 8'h3f;
      4'h1: return 8'h06;
      4'h2: return 8'h5b;
      4'h3: return 8'h4f;
      4'h4: return 8'h66;
      4'h5: return 8'h6d;
      4'h6: return 8'h7d;
      4'h7: return 8'h07;
      4'h8: return 8'h7f;
      4'h9: return 8'h6f;
      4'ha: return 8'h77;
      4'hb: return 8'h7c;
      4'hc: return 8'h39;
      4'hd: return 8'h5e;
      4'he: return 8'h79;
      default: return 8'h71;
    endcase
  endfunction

  assign cur_digit = display[{digit_idx, 2'b00} +: 4];
  assign div_done  = (div_cnt == DW'(SHIFT_DIV - 1));
  // MSB of the frame drives the serial line
  assign ds = frame[15];

  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= LOAD;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      digit_idx <= '0;
      frame     <= '0;
      sh_clk    <= 1'b0;
      ld_clk    <= 1'b0;
    end
    else
    begin
      case (state)
        LOAD:
        begin
          // segments first, then one-hot digit select
          frame   <= {hex_to_seg(cur_digit), 8'(8'd1 << digit_idx)};
          div_cnt <= '0;
          bit_cnt <= '0;
          state   <= SHIFT;
        end
        SHIFT:
        begin
          div_cnt <= div_done ? '0 : div_cnt + 1'b1;
          if (div_done && !sh_clk)
          begin
            sh_clk <= 1'b1;
          end
          else if (div_done)
          begin
            // falling edge, next bit onto ds
            sh_clk <= 1'b0;
            frame  <= frame << 1;
            if (bit_cnt == 4'd15)
            begin
              ld_clk <= 1'b1;
              state  <= LATCH;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default:
        begin
          div_cnt <= div_done ? '0 : div_cnt + 1'b1;
          if (div_done)
          begin
            ld_clk    <= 1'b0;
            digit_idx <= digit_idx + 1'b1;
            state     <= LOAD;
          end
        end
      endcase
    end
  end

endmodule

// ==== source/ahb_seg7x8.sv ====
`timescale 1ns/10ps

module ahb_seg7x8
  import ahb_pkg::*;
  import periph_pkg::*;
#(
  parameter int SHIFT_DIV = 2
)
(
  input  logic     CLK_CM3,
  input  logic     rst_n,
  input  logic     sel,
  input  ahb_req_t bus_req,
  input  hdata_t   hwdata,
  output ahb_rsp_t rsp,
  output logic     sh_clk,
  output logic     ld_clk,
  output logic     ds
);

  // digit 0 in bits 3:0
  hdata_t      display;
  logic        act_q;
  logic        wr_q;
  logic [11:0] offset_q;
  logic        reg_hit;

  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      act_q <= 1'b0;
      wr_q  <= 1'b0;
    end
    else
    begin
      act_q <= sel && (bus_req.htrans == HTRANS_NONSEQ) && bus_req.hready;
      wr_q  <= bus_req.hwrite;
    end
  end

  always_ff @(posedge CLK_CM3)
  begin
    offset_q <= bus_req.haddr[11:0];
  end

  assign reg_hit = act_q && (offset_q == REG_DATA);

  // display value, written at the end of the data phase
  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      display <= '0;
    end
    else if (reg_hit && wr_q)
    begin
      display <= hwdata;
    end
  end

  assign rsp.hrdata    = (reg_hit && !wr_q) ? display : '0;
  assign rsp.hreadyout = 1'b1;
  assign rsp.hresp     = 1'b0;

  seg7_shifter #(.SHIFT_DIV(SHIFT_DIV)) u_shifter (
    .CLK_CM3 (CLK_CM3),
    .rst_n   (rst_n),
    .display (display),
    .sh_clk  (sh_clk),
    .ld_clk  (ld_clk),
    .ds      (ds)
  );

endmodule

// ==== source/ahb_interconnect.sv ====
`timescale 1ns/10ps

module ahb_interconnect
  import ahb_pkg::*;
(
  input  logic     CLK_CM3,
  input  logic     rst_n,
  input  ahb_req_t bus_req,
  output logic     sel_seg7,
  output logic     sel_uart,
  input  ahb_rsp_t rsp_seg7,
  input  ahb_rsp_t rsp_uart,
  output ahb_rsp_t bus_rsp
);

  slot_t addr_slot;
  slot_t data_slot;
  logic  xfer_valid;

  // address phase decode
  assign addr_slot  = bus_req.haddr[SLOT_LSB +: 2];
  assign xfer_valid = (bus_req.htrans == HTRANS_NONSEQ) && bus_req.hready;

  assign sel_seg7 = (addr_slot == SLOT_SEG7);
  assign sel_uart = (addr_slot == SLOT_UART);

  // slot of the transfer now in its data phase
  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // park on a null slot
      data_slot <= '1;
    end
    else if (xfer_valid)
    begin
      data_slot <= addr_slot;
    end
  end

  // response mux; slots 2 and 3 are the null device
  always_comb
  begin
    case (data_slot)
      SLOT_SEG7:
      begin
        bus_rsp = rsp_seg7;
      end
      SLOT_UART:
      begin
        bus_rsp = rsp_uart;
      end
      default:
      begin
        bus_rsp.hrdata    = '0;
        bus_rsp.hreadyout = 1'b1;
        bus_rsp.hresp     = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/ahb_periph_top.sv ====
`timescale 1ns/10ps

module ahb_periph_top
  import ahb_pkg::*;
#(
  parameter int BAUD_DIV  = 8,
  parameter int SHIFT_DIV = 2
)
(
  input  logic     CLK_CM3,
  input  logic     rst_n,
  input  ahb_req_t bus_req,
  input  hdata_t   hwdata,
  output ahb_rsp_t bus_rsp,
  output logic     seg7_sh_cp,
  output logic     seg7_st_cp,
  output logic     seg7_ds,
  output logic     uart_tx
);

  logic     sel_seg7;
  logic     sel_uart;
  ahb_rsp_t rsp_seg7;
  ahb_rsp_t rsp_uart;

  ahb_interconnect u_interconnect (
    .CLK_CM3  (CLK_CM3),
    .rst_n    (rst_n),
    .bus_req  (bus_req),
    .sel_seg7 (sel_seg7),
    .sel_uart (sel_uart),
    .rsp_seg7 (rsp_seg7),
    .rsp_uart (rsp_uart),
    .bus_rsp  (bus_rsp)
  );

  // slot 0, 8 digit display
  ahb_seg7x8 #(.SHIFT_DIV(SHIFT_DIV)) u_seg7 (
    .CLK_CM3 (CLK_CM3),
    .rst_n   (rst_n),
    .sel     (sel_seg7),
    .bus_req (bus_req),
    .hwdata  (hwdata),
    .rsp     (rsp_seg7),
    .sh_clk  (seg7_sh_cp),
    .ld_clk  (seg7_st_cp),
    .ds      (seg7_ds)
  );

  // slot 1, uart tx
  ahb_uart #(.BAUD_DIV(BAUD_DIV)) u_uart (
    .CLK_CM3 (CLK_CM3),
    .rst_n   (rst_n),
    .sel     (sel_uart),
    .bus_req (bus_req),
    .hwdata  (hwdata),
    .rsp     (rsp_uart),
    .tx      (uart_tx)
  );

endmodule

// ==== dv/ahb_periph_props.sv ====
`timescale 1ns/10ps

module ahb_periph_props
  import ahb_pkg::*;
(
  input logic     CLK_CM3,
  input logic     rst_n,
  input ahb_rsp_t bus_rsp,
  input logic     seg7_sh_cp,
  input logic     seg7_st_cp
);

  int rsp_fails = 0;
  int ready_fails = 0;
  int clk_fails = 0;

  // slaves only answer OKAY
  no_error_rsp: assert property (@(posedge CLK_CM3) disable iff (!rst_n) !bus_rsp.hresp)
  else
  begin
    rsp_fails++;
    $error("slave answered with an error response");
  end

  // zero wait states, so no back-pressure
  always_ready: assert property (@(posedge CLK_CM3) disable iff (!rst_n) bus_rsp.hreadyout)
  else
  begin
    ready_fails++;
    $error("hreadyout dropped after reset");
  end

  // 595 shift and latch never overlap
  clocks_apart: assert property (@(posedge CLK_CM3) disable iff (!rst_n)
                                 !(seg7_sh_cp && seg7_st_cp))
  else
  begin
    clk_fails++;
    $error("shift clock and latch clock high together");
  end

endmodule

bind ahb_periph_top ahb_periph_props u_props (
  .CLK_CM3    (CLK_CM3),
  .rst_n      (rst_n),
  .bus_rsp    (bus_rsp),
  .seg7_sh_cp (seg7_sh_cp),
  .seg7_st_cp (seg7_st_cp)
);

// ==== dv/tb_ahb_periph.sv ====
`timescale 1ns/10ps

module tb_ahb_periph
  import ahb_pkg::*;
  import periph_pkg::*;
();

  localparam int BAUD_DIV   = 8;
  localparam int SHIFT_DIV  = 2;
  localparam int CLK_PERIOD = 4;

  // one 595 frame is load, 16 shift periods and the latch pulse
  localparam int FRAME_CYC = 32 * SHIFT_DIV + SHIFT_DIV + 1;
  localparam int UART_CYC  = 10 * BAUD_DIV;
  // 12 display frames, 6 uart frames, plus bus traffic
  localparam int RUN_CYC   = 12 * FRAME_CYC + 6 * (UART_CYC + BAUD_DIV) + 400;

  localparam haddr_t SEG_DATA    = 32'h0000_0000;
  localparam haddr_t UART_DATA   = 32'h0000_1000;
  localparam haddr_t UART_STATUS = 32'h0000_1004;
  localparam haddr_t NULL2_ADDR  = 32'h0000_2000;
  localparam haddr_t NULL3_ADDR  = 32'h0000_3000;

  logic     CLK_CM3;
  logic     rst_n;
  ahb_req_t bus_req;
  hdata_t   hwdata;
  ahb_rsp_t bus_rsp;
  logic     seg7_sh_cp;
  logic     seg7_st_cp;
  logic     seg7_ds;
  logic     uart_tx;

  logic [31:0] lfsr = 32'hc3bd;
  int          main_errs = 0;

  // display monitor state
  hdata_t      disp_exp = '0;
  logic        seg_mon_en = 1'b0;
  logic [15:0] seg_shift = '0;
  int          seg_bits = 0;
  int          seg_frames = 0;
  logic [7:0]  seen = '0;
  int          seg_errs = 0;

  // uart monitor state
  uart_byte_t  uart_exp [0:15];
  int          uart_sent = 0;
  int          uart_frames = 0;
  int          uart_errs = 0;

  ahb_periph_top #(
    .BAUD_DIV  (BAUD_DIV),
    .SHIFT_DIV (SHIFT_DIV)
  ) UUT (
    .CLK_CM3    (CLK_CM3),
    .rst_n      (rst_n),
    .bus_req    (bus_req),
    .hwdata     (hwdata),
    .bus_rsp    (bus_rsp),
    .seg7_sh_cp (seg7_sh_cp),
    .seg7_st_cp (seg7_st_cp),
    .seg7_ds    (seg7_ds),
    .uart_tx    (uart_tx)
  );

  always #(CLK_PERIOD / 2) CLK_CM3 = ~CLK_CM3;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output hdata_t val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // segments g..a in bits 6..0, then one-hot digit select
  function automatic logic [15:0] seg_encode(input digit_t d, input int idx);
    seg_t segs [16];
    segs = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
             8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
    return {segs[d], 8'(1 << idx)};
  endfunction

  // bit i is the i-th bit on the line: start, data lsb first, stop
  function automatic logic [9:0] uart_frame(input uart_byte_t b);
    return {1'b1, b, 1'b0};
  endfunction

  // returns 1 on a mismatch
  function automatic int check_eq(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
    int bad;
    bad = 0;
    assert (act === exp)
    else
    begin
      $display("mismatch %s: expected %h actual %h", name, exp, act);
      bad = 1;
    end
    return bad;
  endfunction

  // address phase, then data phase on the next edge
  task automatic bus_write(input haddr_t addr, input hdata_t data);
    @(posedge CLK_CM3);
    bus_req.haddr  <= addr;
    bus_req.htrans <= HTRANS_NONSEQ;
    bus_req.hwrite <= 1'b1;
    @(posedge CLK_CM3);
    bus_req.htrans <= HTRANS_IDLE;
    bus_req.hwrite <= 1'b0;
    hwdata         <= data;
  endtask

  task automatic bus_read(input haddr_t addr, output hdata_t data);
    @(posedge CLK_CM3);
    bus_req.haddr  <= addr;
    bus_req.htrans <= HTRANS_NONSEQ;
    bus_req.hwrite <= 1'b0;
    @(posedge CLK_CM3);
    bus_req.htrans <= HTRANS_IDLE;
    // hrdata settles within the data phase
    @(negedge CLK_CM3);
    data = bus_rsp.hrdata;
  endtask

  task automatic uart_send(input hdata_t word);
    uart_exp[uart_sent] = word[7:0];
    uart_sent++;
    bus_write(UART_DATA, word);
  endtask

  // stop bit ends within BAUD_DIV cycles of its mid-bit sample
  task automatic wait_line_idle();
    wait (uart_frames == uart_sent);
    repeat (BAUD_DIV) @(negedge CLK_CM3);
  endtask

  // collect ds at rising shift clock, check at the latch pulse
  always @(posedge seg7_sh_cp or posedge seg7_st_cp)
  begin
    int idx;
    idx = 0;
    if (!seg_mon_en)
    begin
      seg_bits   = 0;
      seg_frames = 0;
      seen       = '0;
    end
    else if (seg7_st_cp)
    begin
      seg_errs += check_eq("display frame length", 32'd16, 32'(seg_bits));
      assert ($onehot(seg_shift[7:0]))
      else
      begin
        $display("display frame has no one-hot digit select: %h", seg_shift[7:0]);
        seg_errs++;
      end
      for (int i = 0; i < 8; i++)
      begin
        if (seg_shift[i])
        begin
          idx = i;
        end
      end
      seg_errs += check_eq($sformatf("display frame digit %0d", idx),
                           32'(seg_encode(disp_exp[idx*4 +: 4], idx)), 32'(seg_shift));
      seen[idx] = 1'b1;
      seg_bits  = 0;
      seg_frames++;
    end
    else
    begin
      seg_shift = {seg_shift[14:0], seg7_ds};
      seg_bits++;
    end
  end

  // sample each uart bit in its middle
  always @(negedge uart_tx)
  begin
    logic [9:0] line;
    line = '0;
    if (rst_n)
    begin
      repeat ((BAUD_DIV + 1) / 2) @(negedge CLK_CM3);
      for (int i = 0; i < 10; i++)
      begin
        line[i] = uart_tx;
        if (i < 9)
        begin
          repeat (BAUD_DIV) @(negedge CLK_CM3);
        end
      end
      assert (uart_frames < uart_sent)
      else
      begin
        $display("uart line carried a frame that no accepted write started");
        uart_errs++;
      end
      if (uart_frames < uart_sent)
      begin
        uart_errs += check_eq($sformatf("uart frame %0d", uart_frames),
                              32'(uart_frame(uart_exp[uart_frames])), 32'(line));
      end
      uart_frames++;
    end
  end

  initial
  begin
    #(2 * CLK_PERIOD * RUN_CYC);
    $display("timeout: run did not finish within %0d cycles", 2 * RUN_CYC);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    hdata_t word;
    hdata_t word2;
    hdata_t rd;
    int     prop_errs;
    CLK_CM3 = 1'b0;
    rst_n   = 1'b0;
    bus_req = '0;
    hwdata  = '0;
    bus_req.hready = 1'b1;
    repeat (4) @(posedge CLK_CM3);
    rst_n <= 1'b1;

    // reset values
    @(negedge CLK_CM3);
    main_errs += check_eq("reset uart_tx", 32'd1, 32'(uart_tx));
    main_errs += check_eq("reset shift clock", 32'd0, 32'(seg7_sh_cp));
    main_errs += check_eq("reset latch clock", 32'd0, 32'(seg7_st_cp));
    bus_read(SEG_DATA, rd);
    main_errs += check_eq("reset display data", 32'd0, rd);
    bus_read(UART_DATA, rd);
    main_errs += check_eq("reset uart data", 32'd0, rd);
    bus_read(UART_STATUS, rd);
    main_errs += check_eq("reset uart status", 32'd0, rd);

    // register readback
    rand_bits(32, word);
    bus_write(SEG_DATA, word);
    bus_read(SEG_DATA, rd);
    main_errs += check_eq("display readback", word, rd);
    rand_bits(32, word2);
    uart_send(word2);
    bus_read(UART_DATA, rd);
    main_errs += check_eq("uart readback", {24'd0, word2[7:0]}, rd);
    wait_line_idle();

    // null slots
    rand_bits(32, rd);
    bus_write(NULL2_ADDR, rd);
    bus_write(NULL3_ADDR, ~rd);
    bus_read(NULL2_ADDR, rd);
    main_errs += check_eq("null slot 2 read", 32'd0, rd);
    bus_read(NULL3_ADDR + 32'h4, rd);
    main_errs += check_eq("null slot 3 read", 32'd0, rd);
    bus_read(SEG_DATA, rd);
    main_errs += check_eq("display after null writes", word, rd);
    bus_read(UART_DATA, rd);
    main_errs += check_eq("uart after null writes", {24'd0, word2[7:0]}, rd);

    // display frames, one full round of 8 digits
    rand_bits(32, word);
    disp_exp = word;
    bus_write(SEG_DATA, word);
    repeat (2) @(negedge seg7_st_cp);
    seg_mon_en = 1'b1;
    wait (seg_frames == 8);
    main_errs += check_eq("display digits seen", 32'hff, 32'(seen));
    seg_mon_en = 1'b0;

    // uart output
    repeat (2)
    begin
      rand_bits(8, word);
      uart_send(word);
      wait_line_idle();
    end

    // busy status and a dropped second write
    rand_bits(8, word);
    rand_bits(8, word2);
    uart_send(word);
    bus_read(UART_STATUS, rd);
    main_errs += check_eq("status busy", 32'd1, rd);
    bus_write(UART_DATA, word2);
    bus_read(UART_STATUS, rd);
    main_errs += check_eq("status busy after drop", 32'd1, rd);
    wait_line_idle();
    bus_read(UART_STATUS, rd);
    main_errs += check_eq("status idle", 32'd0, rd);
    // room for a whole extra frame, which must not appear
    repeat (UART_CYC) @(negedge CLK_CM3);
    main_errs += check_eq("uart frame count", 32'(uart_sent), 32'(uart_frames));

    prop_errs = UUT.u_props.rsp_fails + UUT.u_props.ready_fails + UUT.u_props.clk_fails;
    $display("errors: bus %0d, display %0d, uart %0d, assertions %0d",
             main_errs, seg_errs, uart_errs, prop_errs);
    if (main_errs + seg_errs + uart_errs + prop_errs == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/ahb_pkg.sv
source/periph_pkg.sv
source/uart_tx.sv
source/ahb_uart.sv
source/seg7_shifter.sv
source/ahb_seg7x8.sv
source/ahb_interconnect.sv
source/ahb_periph_top.sv
dv/ahb_periph_props.sv
dv/tb_ahb_periph.sv

// ==== Makefile ====
TOP = tb_ahb_periph

all: run

obj_dir/V$(TOP): all.f $(shell cat all.f)
	verilator --binary --timing --assert --timescale 1ns/10ps -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
